// ==== hdl/counter_pkg.sv ====
package counter_pkg;

   localparam int BUS_W      = 32;
   localparam int COUNT_W    = 32; // Counts, timeout and predelay
   localparam int BIN_DATA_W = 18;
   localparam int REP_W      = 16;
   localparam int TRIG_W     = 8;

   localparam logic [COUNT_W-1:0] DEFAULT_TIMEOUT = 32'd125;

   // Register map
   localparam logic [BUS_W-1:0] ADDR_CMD       = 32'h0000_0000;
   localparam logic [BUS_W-1:0] ADDR_TIMEOUT   = 32'h0000_0004;
   localparam logic [BUS_W-1:0] ADDR_LAST0     = 32'h0000_0008;
   localparam logic [BUS_W-1:0] ADDR_LAST1     = 32'h0000_000C;
   localparam logic [BUS_W-1:0] ADDR_BINS      = 32'h0000_0010;
   localparam logic [BUS_W-1:0] ADDR_REPS      = 32'h0000_0014;
   localparam logic [BUS_W-1:0] ADDR_PREDELAY  = 32'h0000_0018;
   localparam logic [BUS_W-1:0] ADDR_TRIG_CFG  = 32'h0000_001C;
   localparam logic [BUS_W-1:0] ADDR_BIN_INDEX = 32'h0000_0020;
   localparam logic [BUS_W-1:0] ADDR_REP_INDEX = 32'h0000_0024;
   localparam logic [BUS_W-1:0] RAM_BASE       = 32'h0001_0000;
   localparam logic [BUS_W-1:0] RAM_CH_STRIDE  = 32'h0000_4000; // One bin memory per stride

   typedef enum logic [2:0] {
      none            = 3'd0,
      go_idle         = 3'd1,
      clear           = 3'd2,
      count_immediate = 3'd3,
      count_triggered = 3'd4,
      soft_trigger    = 3'd5
   } cmd_e;

   // Encoding is visible to software at ADDR_CMD
   typedef enum logic [2:0] {
      idle              = 3'd0,
      imm_start         = 3'd1,
      imm_wait_timeout  = 3'd2,
      trig_wait_trigger = 3'd3,
      trig_store        = 3'd4,
      trig_predelay     = 3'd5,
      trig_prestore     = 3'd6,
      trig_wait_timeout = 3'd7
   } state_e;

   typedef struct packed {
      logic [BUS_W-1:0] addr;
      logic [BUS_W-1:0] wdata;
      logic             wen;
      logic             ren;
   } bus_req_t;

   typedef struct packed {
      logic [COUNT_W-1:0] timeout;
      logic [COUNT_W-1:0] predelay;
      logic [15:0]        bins_in_use;
      logic [REP_W-1:0]   reps;
      logic [TRIG_W-1:0]  trig_mask;
      logic [TRIG_W-1:0]  trig_invert;
      logic               trig_polarity;
   } count_cfg_t;

   typedef struct packed {
      state_e           state;
      logic [15:0]      bin_index;
      logic [REP_W-1:0] rep_index;
   } count_status_t;

endpackage

// ==== hdl/edge_counter.sv ====
`timescale 1ns/1ns

module edge_counter (
   input  logic                            i_clk,
   input  logic                            i_rstn,
   input  logic                            i_signal,
   input  logic                            i_hold_clear,
   output logic [counter_pkg::COUNT_W-1:0] o_count
);

   logic signal_q;
   logic rise;

   assign rise = i_signal && !signal_q;

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         signal_q <= 1'b0;
         o_count  <= '0;
      end else begin
         signal_q <= i_signal;
         if (i_hold_clear) begin
            o_count <= '0;
         end else if (rise) begin
            o_count <= o_count + 1'b1;
         end
      end
   end

endmodule

// ==== hdl/trigger_match.sv ====
`timescale 1ns/1ns

module trigger_match #(
   parameter int NUM_INPUTS = 4
) (
   input  logic                    i_clk,
   input  logic                    i_rstn,
   input  logic [NUM_INPUTS-1:0]   i_inputs,
   input  counter_pkg::count_cfg_t i_cfg,
   output logic [NUM_INPUTS-1:0]   o_sync_inputs,
   output logic                    o_trigger
);

   typedef logic [counter_pkg::TRIG_W-1:0] trig_vec_t;

   logic [NUM_INPUTS-1:0] meta; // First synchronizer stage
   trig_vec_t             inputs_wide;
   logic                  all_set;

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         meta          <= '0;
         o_sync_inputs <= '0;
      end else begin
         meta          <= i_inputs;
         o_sync_inputs <= meta;
      end
   end

   // Every masked input high after inversion
   assign inputs_wide = trig_vec_t'(o_sync_inputs);
   assign all_set     = ((inputs_wide ^ i_cfg.trig_invert) & i_cfg.trig_mask) == i_cfg.trig_mask;
   assign o_trigger   = (all_set == i_cfg.trig_polarity);

endmodule

// ==== hdl/bin_ram.sv ====
`timescale 1ns/1ns

module bin_ram #(
   parameter int BIN_ADDR_W = 10
) (
   input  logic                               i_clk,
   input  logic [BIN_ADDR_W-1:0]              i_addr_a,
   input  logic                               i_we_a,
   input  logic [counter_pkg::BIN_DATA_W-1:0] i_data_a,
   output logic [counter_pkg::BIN_DATA_W-1:0] o_data_a,
   input  logic [BIN_ADDR_W-1:0]              i_addr_b,
   input  logic                               i_we_b,
   input  logic [counter_pkg::BIN_DATA_W-1:0] i_data_b,
   output logic [counter_pkg::BIN_DATA_W-1:0] o_data_b
);

   logic [counter_pkg::BIN_DATA_W-1:0] mem [2**BIN_ADDR_W];

   // Port A, sequencer side
   always @(posedge i_clk) begin
      if (i_we_a) mem[i_addr_a] <= i_data_a;
      o_data_a <= mem[i_addr_a]; // Old data on a same-cycle write
   end

   // Port B, bus side
   always @(posedge i_clk) begin
      if (i_we_b) mem[i_addr_b] <= i_data_b;
      o_data_b <= mem[i_addr_b];
   end

endmodule

// ==== hdl/count_sequencer.sv ====
`timescale 1ns/1ns

module count_sequencer #(
   parameter int NUM_CHANNELS = 2,
   parameter int BIN_ADDR_W   = 10
) (
   input  logic                                                 i_clk,
   input  logic                                                 i_rstn,
   input  logic                                                 i_cmd_valid,
   input  counter_pkg::cmd_e                                    i_cmd,
   input  counter_pkg::count_cfg_t                              i_cfg,
   input  logic                                                 i_trigger,
   input  logic [NUM_CHANNELS-1:0][counter_pkg::COUNT_W-1:0]    i_counts,
   input  logic [NUM_CHANNELS-1:0][counter_pkg::BIN_DATA_W-1:0] i_ram_rdata,
   output logic                                                 o_hold_clear,
   output logic [NUM_CHANNELS-1:0][counter_pkg::COUNT_W-1:0]    o_last_counts,
   output logic [BIN_ADDR_W-1:0]                                o_ram_addr,
   output logic [NUM_CHANNELS-1:0][counter_pkg::BIN_DATA_W-1:0] o_ram_wdata,
   output logic                                                 o_ram_we,
   output counter_pkg::count_status_t                           o_status
);

   counter_pkg::state_e             state;
   logic [counter_pkg::COUNT_W-1:0] timer;   // Predelay and window down-counter
   logic [BIN_ADDR_W-1:0]           bin_idx;
   logic [counter_pkg::REP_W-1:0]   rep_idx;
   logic                            fire;
   logic                            mode_cmd;
   logic                            last_bin;

   assign fire     = i_trigger || (i_cmd_valid && i_cmd == counter_pkg::soft_trigger);
   assign mode_cmd = i_cmd_valid && !(i_cmd inside {counter_pkg::none, counter_pkg::soft_trigger});
   assign last_bin = (16'(bin_idx) == i_cfg.bins_in_use - 16'd1);

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         state         <= counter_pkg::idle;
         timer         <= '0;
         bin_idx       <= '0;
         rep_idx       <= '0;
         o_hold_clear  <= 1'b1;
         o_ram_we      <= 1'b0;
         o_last_counts <= '0;
      end else if (mode_cmd) begin
         o_hold_clear <= 1'b1; // Any mode change stops a running window
         o_ram_we     <= 1'b0;
         case (i_cmd)
            counter_pkg::go_idle:         state <= counter_pkg::idle;
            counter_pkg::count_immediate: state <= counter_pkg::imm_start;
            counter_pkg::count_triggered: state <= counter_pkg::trig_wait_trigger;
            default: begin
               o_last_counts <= '0;
               bin_idx       <= '0;
               rep_idx       <= '0;
               state         <= counter_pkg::idle;
            end
         endcase
      end else begin
         case (state)
            counter_pkg::idle: begin
               o_hold_clear <= 1'b1;
               o_ram_we     <= 1'b0;
            end
            counter_pkg::imm_start: begin
               timer        <= i_cfg.timeout;
               o_hold_clear <= 1'b0;
               state        <= counter_pkg::imm_wait_timeout;
            end
            counter_pkg::imm_wait_timeout, counter_pkg::trig_wait_timeout: begin
               if (timer == '0) begin
                  o_last_counts <= i_counts;
                  o_hold_clear  <= 1'b1;
                  state <= (state == counter_pkg::imm_wait_timeout) ?
                           counter_pkg::idle : counter_pkg::trig_prestore;
               end else begin
                  timer <= timer - 1'b1;
               end
            end
            counter_pkg::trig_wait_trigger: begin
               if (fire && i_cfg.predelay == '0) begin
                  timer        <= i_cfg.timeout;
                  o_hold_clear <= 1'b0;
                  state        <= counter_pkg::trig_wait_timeout;
               end else if (fire) begin
                  timer <= i_cfg.predelay - 1'b1; // One cycle already spent here
                  state <= counter_pkg::trig_predelay;
               end
            end
            counter_pkg::trig_predelay: begin
               if (timer == '0) begin
                  timer        <= i_cfg.timeout;
                  o_hold_clear <= 1'b0;
                  state        <= counter_pkg::trig_wait_timeout;
               end else begin
                  timer <= timer - 1'b1;
               end
            end
            counter_pkg::trig_prestore: begin
               o_ram_we <= 1'b1;
               state    <= counter_pkg::trig_store;
            end
            counter_pkg::trig_store: begin
               o_ram_we <= 1'b0;
               if (rep_idx == i_cfg.reps) begin
                  rep_idx <= '0;
                  bin_idx <= last_bin ? '0 : bin_idx + 1'b1;
               end else begin
                  rep_idx <= rep_idx + 1'b1;
               end
               state <= counter_pkg::trig_wait_trigger;
            end
            default: state <= counter_pkg::idle;
         endcase
      end
   end

   // Accumulated bin word, written during trig_store
   always_ff @(posedge i_clk) begin
      if (state == counter_pkg::trig_prestore) begin
         for (int i = 0; i < NUM_CHANNELS; i++) begin
            o_ram_wdata[i] <= i_ram_rdata[i] + o_last_counts[i][counter_pkg::BIN_DATA_W-1:0];
         end
      end
   end

   assign o_ram_addr         = bin_idx;
   assign o_status.state     = state;
   assign o_status.bin_index = 16'(bin_idx);
   assign o_status.rep_index = rep_idx;

endmodule

// ==== hdl/bus_regs.sv ====
`timescale 1ns/1ns

module bus_regs #(
   parameter int NUM_CHANNELS = 2,
   parameter int BIN_ADDR_W   = 10
) (
   input  logic                                                 i_clk,
   input  logic                                                 i_rstn,
   input  counter_pkg::bus_req_t                                i_bus,
   input  counter_pkg::count_status_t                           i_status,
   input  logic [NUM_CHANNELS-1:0][counter_pkg::COUNT_W-1:0]    i_last_counts,
   input  logic [NUM_CHANNELS-1:0][counter_pkg::BIN_DATA_W-1:0] i_ram_rdata,
   output logic                                                 o_cmd_valid,
   output counter_pkg::cmd_e                                    o_cmd,
   output counter_pkg::count_cfg_t                              o_cfg,
   output logic [BIN_ADDR_W-1:0]                                o_ram_addr,
   output logic [$clog2(NUM_CHANNELS)-1:0]                      o_ram_sel,
   output logic [counter_pkg::BIN_DATA_W-1:0]                   o_ram_wdata,
   output logic                                                 o_ram_we,
   output logic [counter_pkg::BUS_W-1:0]                        o_rdata,
   output logic                                                 o_ack,
   output logic                                                 o_err
);

   typedef logic [counter_pkg::BUS_W-1:0] word_t;

   localparam int    SEL_LSB = $clog2(counter_pkg::RAM_CH_STRIDE);
   localparam word_t RAM_END = counter_pkg::RAM_BASE +
                               word_t'(NUM_CHANNELS) * counter_pkg::RAM_CH_STRIDE;

   logic       strobe;
   logic       ram_hit;
   logic [1:0] ram_wait;  // Cycles left before a RAM access acks
   word_t      reg_rdata;

   assign strobe  = (i_bus.wen || i_bus.ren) && ram_wait == 2'd0;
   assign ram_hit = i_bus.addr >= counter_pkg::RAM_BASE && i_bus.addr < RAM_END;
   assign o_err   = 1'b0;

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_cmd_valid         <= 1'b0;
         o_cmd               <= counter_pkg::none;
         o_cfg.timeout       <= counter_pkg::DEFAULT_TIMEOUT;
         o_cfg.predelay      <= '0;
         o_cfg.bins_in_use   <= 16'(2**BIN_ADDR_W);
         o_cfg.reps          <= '0;
         o_cfg.trig_mask     <= '0;
         o_cfg.trig_invert   <= '0;
         o_cfg.trig_polarity <= 1'b0;
      end else begin
         o_cmd_valid <= 1'b0;
         if (strobe && i_bus.wen) begin
            case (i_bus.addr)
               counter_pkg::ADDR_CMD: begin
                  o_cmd_valid <= 1'b1;
                  case (i_bus.wdata)
                     32'd1:   o_cmd <= counter_pkg::go_idle;
                     32'd2:   o_cmd <= counter_pkg::clear;
                     32'd3:   o_cmd <= counter_pkg::count_immediate;
                     32'd4:   o_cmd <= counter_pkg::count_triggered;
                     32'd5:   o_cmd <= counter_pkg::soft_trigger;
                     default: o_cmd <= counter_pkg::none;
                  endcase
               end
               counter_pkg::ADDR_TIMEOUT:  o_cfg.timeout     <= i_bus.wdata;
               counter_pkg::ADDR_BINS:     o_cfg.bins_in_use <= i_bus.wdata[15:0];
               counter_pkg::ADDR_REPS:     o_cfg.reps        <= i_bus.wdata[counter_pkg::REP_W-1:0];
               counter_pkg::ADDR_PREDELAY: o_cfg.predelay    <= i_bus.wdata;
               counter_pkg::ADDR_TRIG_CFG: begin
                  o_cfg.trig_mask     <= i_bus.wdata[7:0];
                  o_cfg.trig_invert   <= i_bus.wdata[15:8];
                  o_cfg.trig_polarity <= i_bus.wdata[16];
               end
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (i_bus.addr)
         counter_pkg::ADDR_CMD:       reg_rdata = word_t'(i_status.state);
         counter_pkg::ADDR_TIMEOUT:   reg_rdata = o_cfg.timeout;
         counter_pkg::ADDR_LAST0:     reg_rdata = i_last_counts[0];
         counter_pkg::ADDR_LAST1:     reg_rdata = i_last_counts[1];
         counter_pkg::ADDR_BINS:      reg_rdata = word_t'(o_cfg.bins_in_use);
         counter_pkg::ADDR_REPS:      reg_rdata = word_t'(o_cfg.reps);
         counter_pkg::ADDR_PREDELAY:  reg_rdata = o_cfg.predelay;
         counter_pkg::ADDR_TRIG_CFG:
            reg_rdata = word_t'({o_cfg.trig_polarity, o_cfg.trig_invert, o_cfg.trig_mask});
         counter_pkg::ADDR_BIN_INDEX: reg_rdata = word_t'(i_status.bin_index);
         counter_pkg::ADDR_REP_INDEX: reg_rdata = word_t'(i_status.rep_index);
         default:                     reg_rdata = '0; // Unmapped reads zero
      endcase
   end

   // Ack timing, one cycle for registers and four for RAM
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_ack    <= 1'b0;
         o_ram_we <= 1'b0;
         ram_wait <= 2'd0;
      end else begin
         o_ack    <= 1'b0;
         o_ram_we <= 1'b0;
         if (ram_wait != 2'd0) begin
            ram_wait <= ram_wait - 2'd1;
            o_ack    <= (ram_wait == 2'd1);
         end else if (strobe && ram_hit) begin
            ram_wait <= 2'd3;
            o_ram_we <= i_bus.wen;
         end else if (strobe) begin
            o_ack <= 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (strobe && ram_hit) begin
         o_ram_addr  <= i_bus.addr[BIN_ADDR_W+1:2];
         o_ram_sel   <= i_bus.addr[SEL_LSB +: $clog2(NUM_CHANNELS)];
         o_ram_wdata <= i_bus.wdata[counter_pkg::BIN_DATA_W-1:0];
      end
      if (ram_wait == 2'd1) begin
         o_rdata <= word_t'(i_ram_rdata[o_ram_sel]);
      end else if (strobe && !ram_hit) begin
         o_rdata <= reg_rdata;
      end
   end

endmodule

// ==== hdl/photon_counter_top.sv ====
`timescale 1ns/1ns

module photon_counter_top #(
   parameter int NUM_INPUTS   = 4,
   parameter int NUM_CHANNELS = 2,
   parameter int BIN_ADDR_W   = 10
) (
   input  logic                          i_clk,
   input  logic                          i_rstn,
   input  logic [NUM_INPUTS-1:0]         i_inputs,
   input  counter_pkg::bus_req_t         i_bus,
   output logic [counter_pkg::BUS_W-1:0] o_rdata,
   output logic                          o_ack,
   output logic                          o_err
);

   logic [NUM_INPUTS-1:0]                                sync_inputs;
   logic                                                 trigger;
   logic                                                 cmd_valid;
   counter_pkg::cmd_e                                    cmd;
   counter_pkg::count_cfg_t                              cfg;
   counter_pkg::count_status_t                           status;
   logic                                                 hold_clear;
   logic [NUM_CHANNELS-1:0][counter_pkg::COUNT_W-1:0]    counts;
   logic [NUM_CHANNELS-1:0][counter_pkg::COUNT_W-1:0]    last_counts;
   logic [BIN_ADDR_W-1:0]                                seq_ram_addr;
   logic [NUM_CHANNELS-1:0][counter_pkg::BIN_DATA_W-1:0] seq_ram_wdata;
   logic [NUM_CHANNELS-1:0][counter_pkg::BIN_DATA_W-1:0] seq_ram_rdata;
   logic                                                 seq_ram_we;
   logic [BIN_ADDR_W-1:0]                                bus_ram_addr;
   logic [$clog2(NUM_CHANNELS)-1:0]                      bus_ram_sel;
   logic [counter_pkg::BIN_DATA_W-1:0]                   bus_ram_wdata;
   logic [NUM_CHANNELS-1:0][counter_pkg::BIN_DATA_W-1:0] bus_ram_rdata;
   logic                                                 bus_ram_we;

   trigger_match #(.NUM_INPUTS(NUM_INPUTS)) u_trigger (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_inputs(i_inputs), .i_cfg(cfg),
      .o_sync_inputs(sync_inputs), .o_trigger(trigger)
   );

   bus_regs #(.NUM_CHANNELS(NUM_CHANNELS), .BIN_ADDR_W(BIN_ADDR_W)) u_regs (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_bus(i_bus), .i_status(status),
      .i_last_counts(last_counts), .i_ram_rdata(bus_ram_rdata),
      .o_cmd_valid(cmd_valid), .o_cmd(cmd), .o_cfg(cfg),
      .o_ram_addr(bus_ram_addr), .o_ram_sel(bus_ram_sel),
      .o_ram_wdata(bus_ram_wdata), .o_ram_we(bus_ram_we),
      .o_rdata(o_rdata), .o_ack(o_ack), .o_err(o_err)
   );

   count_sequencer #(.NUM_CHANNELS(NUM_CHANNELS), .BIN_ADDR_W(BIN_ADDR_W)) u_seq (
      .i_clk(i_clk), .i_rstn(i_rstn), .i_cmd_valid(cmd_valid), .i_cmd(cmd),
      .i_cfg(cfg), .i_trigger(trigger), .i_counts(counts),
      .i_ram_rdata(seq_ram_rdata), .o_hold_clear(hold_clear),
      .o_last_counts(last_counts), .o_ram_addr(seq_ram_addr),
      .o_ram_wdata(seq_ram_wdata), .o_ram_we(seq_ram_we), .o_status(status)
   );

   // One counter and one bin memory per channel
   for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
      edge_counter u_counter (
         .i_clk(i_clk), .i_rstn(i_rstn), .i_signal(sync_inputs[i]),
         .i_hold_clear(hold_clear), .o_count(counts[i])
      );

      bin_ram #(.BIN_ADDR_W(BIN_ADDR_W)) u_bins (
         .i_clk(i_clk),
         .i_addr_a(seq_ram_addr), .i_we_a(seq_ram_we),
         .i_data_a(seq_ram_wdata[i]), .o_data_a(seq_ram_rdata[i]),
         .i_addr_b(bus_ram_addr), .i_we_b(bus_ram_we && bus_ram_sel == i),
         .i_data_b(bus_ram_wdata), .o_data_b(bus_ram_rdata[i])
      );
   end

endmodule

// ==== testbench/tb_photon_counter.sv ====
`timescale 1ns/1ns

module tb_photon_counter;

   // Sequencer states and commands as software sees them
   localparam logic [31:0] ST_IDLE        = 32'd0;
   localparam logic [31:0] ST_IMM_WINDOW  = 32'd2;
   localparam logic [31:0] ST_TRIG_WAIT   = 32'd3;
   localparam logic [31:0] ST_TRIG_WINDOW = 32'd7;
   localparam logic [31:0] CMD_GO_IDLE    = 32'd1;
   localparam logic [31:0] CMD_CLEAR      = 32'd2;
   localparam logic [31:0] CMD_IMMEDIATE  = 32'd3;
   localparam logic [31:0] CMD_TRIGGERED  = 32'd4;
   localparam logic [31:0] CMD_SOFT_TRIG  = 32'd5;
   localparam logic [31:0] CH1_BASE = counter_pkg::RAM_BASE + counter_pkg::RAM_CH_STRIDE;

   logic                  clk;
   logic                  rstn;
   logic [3:0]            inputs;
   counter_pkg::bus_req_t bus;
   logic [31:0]           rdata;
   logic                  ack;
   logic                  err;
   int                    errors = 0;
   int                    checks = 0;
   int                    seed   = 37143;

   photon_counter_top u_dut (
      .i_clk(clk), .i_rstn(rstn), .i_inputs(inputs), .i_bus(bus),
      .o_rdata(rdata), .o_ack(ack), .o_err(err)
   );

   always #50 clk = ~clk;

   function automatic int random_count();
      return ($unsigned($random(seed)) % 20) + 1; // 1 to 20 pulses
   endfunction

   task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   // Strobe already dropped, now at 5 ns after an edge
   task automatic wait_ack(input logic [31:0] addr);
      int cycles;
      cycles = 0;
      while (!ack && cycles < 20) begin
         @(posedge clk);
         #5;
         cycles++;
      end
      assert (ack) else begin
         $display("Bus access to address 0x%08h was never acknowledged", addr);
         errors++;
      end
      check_equal("err", err, 32'd0); // Bus never reports an error
   endtask

   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
      bus.addr  = addr;
      bus.wdata = data;
      bus.wen   = 1'b1;
      @(posedge clk);
      #5;
      bus.wen = 1'b0;
      wait_ack(addr);
      @(posedge clk); // Let a command reach the sequencer
      #5;
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
      bus.addr = addr;
      bus.ren  = 1'b1;
      @(posedge clk);
      #5;
      bus.ren = 1'b0;
      wait_ack(addr);
      data = rdata;
   endtask

   task automatic read_and_check(input logic [31:0] addr, input string name,
                                 input logic [31:0] exp);
      logic [31:0] data;
      bus_read(addr, data);
      check_equal(name, data, exp);
   endtask

   task automatic wait_state(input logic [31:0] exp);
      logic [31:0] state;
      int          tries;
      tries = 0;
      bus_read(counter_pkg::ADDR_CMD, state);
      while (state !== exp && tries < 1000) begin
         bus_read(counter_pkg::ADDR_CMD, state);
         tries++;
      end
      assert (state === exp) else begin
         $display("Timed out waiting for state %0d, last state read was %0d", exp, state);
         errors++;
      end
   endtask

   task automatic send_pulses(input int idx, input int n);
      for (int i = 0; i < n; i++) begin
         inputs[idx] = 1'b1;
         @(posedge clk);
         #5;
         inputs[idx] = 1'b0;
         @(posedge clk);
         #5;
      end
   endtask

   initial begin
      int n0;
      int n1;
      int sum0[2];
      int sum1[2];
      clk    = 1'b0;
      rstn   = 1'b0;
      inputs = '0;
      bus    = '0;
      sum0   = '{0, 0};
      sum1   = '{0, 0};
      repeat (10) @(posedge clk);
      #5;
      rstn = 1'b1;

      // Reset defaults
      read_and_check(counter_pkg::ADDR_CMD, "state", ST_IDLE);
      read_and_check(counter_pkg::ADDR_TIMEOUT, "timeout", 32'd125);
      read_and_check(counter_pkg::ADDR_BINS, "bins", 32'd1024);
      read_and_check(counter_pkg::ADDR_REPS, "reps", 32'd0);
      read_and_check(counter_pkg::ADDR_PREDELAY, "predelay", 32'd0);
      read_and_check(counter_pkg::ADDR_TRIG_CFG, "trig_cfg", 32'd0);

      // Register readback and unmapped addresses
      bus_write(counter_pkg::ADDR_TIMEOUT, 32'd400);
      bus_write(counter_pkg::ADDR_BINS, 32'd5);
      bus_write(counter_pkg::ADDR_REPS, 32'd3);
      bus_write(counter_pkg::ADDR_PREDELAY, 32'd7);
      bus_write(counter_pkg::ADDR_TRIG_CFG, 32'h0001_A55A);
      read_and_check(counter_pkg::ADDR_TIMEOUT, "timeout", 32'd400);
      read_and_check(counter_pkg::ADDR_BINS, "bins", 32'd5);
      read_and_check(counter_pkg::ADDR_REPS, "reps", 32'd3);
      read_and_check(counter_pkg::ADDR_PREDELAY, "predelay", 32'd7);
      read_and_check(counter_pkg::ADDR_TRIG_CFG, "trig_cfg", 32'h0001_A55A);
      bus_write(32'h0000_0040, 32'hDEAD_BEEF);
      read_and_check(32'h0000_0040, "unmapped 0x40", 32'd0);
      read_and_check(32'h0002_0000, "unmapped 0x20000", 32'd0);
      bus_write(counter_pkg::ADDR_BINS, 32'd2);
      bus_write(counter_pkg::ADDR_REPS, 32'd1);
      bus_write(counter_pkg::ADDR_PREDELAY, 32'd0);
      bus_write(counter_pkg::ADDR_TRIG_CFG, 32'd0);

      // Immediate counting
      bus_write(counter_pkg::ADDR_CMD, CMD_IMMEDIATE);
      wait_state(ST_IMM_WINDOW);
      n0 = random_count();
      n1 = random_count();
      send_pulses(0, n0);
      send_pulses(1, n1);
      wait_state(ST_IDLE);
      read_and_check(counter_pkg::ADDR_LAST0, "last0", n0);
      read_and_check(counter_pkg::ADDR_LAST1, "last1", n1);

      // Triggered accumulation, two windows per bin
      bus_write(counter_pkg::RAM_BASE, 32'd0);
      bus_write(counter_pkg::RAM_BASE + 32'd4, 32'd0);
      bus_write(CH1_BASE, 32'd0);
      bus_write(CH1_BASE + 32'd4, 32'd0);
      bus_write(counter_pkg::ADDR_CMD, CMD_TRIGGERED);
      for (int w = 0; w < 4; w++) begin
         wait_state(ST_TRIG_WAIT);
         bus_write(counter_pkg::ADDR_CMD, CMD_SOFT_TRIG);
         wait_state(ST_TRIG_WINDOW);
         n0 = random_count();
         n1 = random_count();
         send_pulses(0, n0);
         send_pulses(1, n1);
         wait_state(ST_TRIG_WAIT);
         read_and_check(counter_pkg::ADDR_LAST0, "last0", n0);
         read_and_check(counter_pkg::ADDR_LAST1, "last1", n1);
         sum0[w/2] += n0;
         sum1[w/2] += n1;
      end
      read_and_check(counter_pkg::ADDR_BIN_INDEX, "bin_index", 32'd0);
      read_and_check(counter_pkg::ADDR_REP_INDEX, "rep_index", 32'd0);
      read_and_check(counter_pkg::RAM_BASE, "ch0 bin 0", sum0[0]);
      read_and_check(counter_pkg::RAM_BASE + 32'd4, "ch0 bin 1", sum0[1]);
      read_and_check(CH1_BASE, "ch1 bin 0", sum1[0]);
      read_and_check(CH1_BASE + 32'd4, "ch1 bin 1", sum1[1]);

      // Input 3 trigger, high polarity, predelay 20
      bus_write(counter_pkg::ADDR_CMD, CMD_GO_IDLE);
      bus_write(counter_pkg::ADDR_TRIG_CFG, 32'h0001_0008);
      bus_write(counter_pkg::ADDR_PREDELAY, 32'd20);
      bus_write(counter_pkg::ADDR_REPS, 32'd0); // New bin after every window
      bus_write(counter_pkg::ADDR_CMD, CMD_TRIGGERED);
      for (int i = 0; i < 5; i++) begin
         read_and_check(counter_pkg::ADDR_CMD, "state", ST_TRIG_WAIT);
      end
      inputs[3] = 1'b1;
      wait_state(ST_TRIG_WINDOW);
      inputs[3] = 1'b0;   // One window only
      n0 = random_count();
      send_pulses(0, n0);
      wait_state(ST_TRIG_WAIT);
      read_and_check(counter_pkg::ADDR_LAST0, "last0", n0);
      read_and_check(counter_pkg::ADDR_LAST1, "last1", 32'd0);
      read_and_check(counter_pkg::ADDR_BIN_INDEX, "bin_index", 32'd1);

      // Soft-triggered window leaving both indices and counts nonzero
      bus_write(counter_pkg::ADDR_REPS, 32'd1);
      bus_write(counter_pkg::ADDR_CMD, CMD_SOFT_TRIG);
      wait_state(ST_TRIG_WINDOW);
      n0 = random_count();
      n1 = random_count();
      send_pulses(0, n0);
      send_pulses(1, n1);
      wait_state(ST_TRIG_WAIT);
      read_and_check(counter_pkg::ADDR_LAST0, "last0", n0);
      read_and_check(counter_pkg::ADDR_LAST1, "last1", n1);
      read_and_check(counter_pkg::ADDR_BIN_INDEX, "bin_index", 32'd1);
      read_and_check(counter_pkg::ADDR_REP_INDEX, "rep_index", 32'd1);

      // Abort, clear and direct RAM access
      bus_write(counter_pkg::ADDR_CMD, CMD_IMMEDIATE);
      wait_state(ST_IMM_WINDOW);
      send_pulses(0, 5);
      bus_write(counter_pkg::ADDR_CMD, CMD_GO_IDLE);
      read_and_check(counter_pkg::ADDR_CMD, "state", ST_IDLE);
      bus_write(counter_pkg::ADDR_CMD, CMD_CLEAR);
      read_and_check(counter_pkg::ADDR_CMD, "state", ST_IDLE);
      read_and_check(counter_pkg::ADDR_LAST0, "last0", 32'd0);
      read_and_check(counter_pkg::ADDR_LAST1, "last1", 32'd0);
      read_and_check(counter_pkg::ADDR_BIN_INDEX, "bin_index", 32'd0);
      read_and_check(counter_pkg::ADDR_REP_INDEX, "rep_index", 32'd0);
      bus_write(counter_pkg::RAM_BASE + 32'd20, 32'h0001_1234);
      bus_write(CH1_BASE + 32'd20, 32'h0002_A5A5);
      read_and_check(counter_pkg::RAM_BASE + 32'd20, "ch0 word 5", 32'h0001_1234);
      read_and_check(CH1_BASE + 32'd20, "ch1 word 5", 32'h0002_A5A5);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== photon_counter_top.f ====
hdl/counter_pkg.sv
hdl/edge_counter.sv
hdl/trigger_match.sv
hdl/bin_ram.sv
hdl/count_sequencer.sv
hdl/bus_regs.sv
hdl/photon_counter_top.sv
testbench/tb_photon_counter.sv
